// ==== src/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 64;
    // one shift step per operand bit
    localparam int ITER_COUNT = 64;

    // bus word addresses
    localparam logic [1:0] REG_OP1    = 2'd0;
    localparam logic [1:0] REG_OP2    = 2'd1;
    localparam logic [1:0] REG_OPCODE = 2'd2;
    localparam logic [1:0] REG_RESULT = 2'd3;

    typedef enum logic [4:0] {
        // single-cycle alu
        ADD    = 5'd0,
        SUB    = 5'd1,
        SLT    = 5'd2,
        SLTU   = 5'd3,
        XOR    = 5'd4,
        OR     = 5'd5,
        AND    = 5'd6,
        SLL    = 5'd7,
        SRL    = 5'd8,
        SRA    = 5'd9,
        ADDW   = 5'd10,
        SUBW   = 5'd11,
        SLLW   = 5'd12,
        SRLW   = 5'd13,
        SRAW   = 5'd14,
        // multiplier
        MUL    = 5'd15,
        MULH   = 5'd16,
        MULHU  = 5'd17,
        MULHSU = 5'd18,
        MULW   = 5'd19,
        // divider
        DIV    = 5'd20,
        DIVU   = 5'd21,
        REM    = 5'd22,
        REMU   = 5'd23,
        DIVW   = 5'd24,
        DIVUW  = 5'd25,
        REMW   = 5'd26,
        REMUW  = 5'd27
    } ex_op_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } ex_state_e;

endpackage

`default_nettype wire

// ==== src/ex_multiplier.sv ====
`default_nettype none

module ex_multiplier (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    start_i,
    input  ex_pkg::ex_op_e          op_i,
    input  logic [ex_pkg::XLEN-1:0] op1_i,
    input  logic [ex_pkg::XLEN-1:0] op2_i,
    output logic [ex_pkg::XLEN-1:0] result_o,
    output logic                    done_o
);

    import ex_pkg::*;

    localparam int CNT_W = $clog2(ITER_COUNT);

    logic              busy;
    logic [CNT_W-1:0]  cnt;
    ex_op_e            op_q;
    logic              neg_q;
    logic [XLEN-1:0]   mcand_q;
    logic [2*XLEN-1:0] prod_q;
    logic              op1_neg;
    logic              op2_neg;
    logic [XLEN-1:0]   op1_mag;
    logic [XLEN-1:0]   op2_mag;
    logic [XLEN:0]     partial;
    logic [2*XLEN-1:0] prod_fixed;

    // MULHSU treats only op1 as signed
    assign op1_neg = ((op_i == MULH) || (op_i == MULHSU)) && op1_i[XLEN-1];
    assign op2_neg = (op_i == MULH) && op2_i[XLEN-1];
    assign op1_mag = op1_neg ? -op1_i : op1_i;
    assign op2_mag = op2_neg ? -op2_i : op2_i;

    // add into upper half, then shift the whole product right
    assign partial = {1'b0, prod_q[2*XLEN-1:XLEN]} + (prod_q[0] ? {1'b0, mcand_q} : '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(ITER_COUNT - 1)) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end else if (start_i) begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (busy) begin
            prod_q <= {partial, prod_q[XLEN-1:1]};
        end else if (start_i) begin
            op_q    <= op_i;
            neg_q   <= op1_neg ^ op2_neg;
            mcand_q <= op1_mag;
            prod_q  <= {{XLEN{1'b0}}, op2_mag};
        end
    end

    assign prod_fixed = neg_q ? -prod_q : prod_q;

    always_comb begin
        case (op_q)
            MUL:                 result_o = prod_fixed[XLEN-1:0];
            MULH, MULHU, MULHSU: result_o = prod_fixed[2*XLEN-1:XLEN];
            MULW:                result_o = {{(XLEN-32){prod_fixed[31]}}, prod_fixed[31:0]};
            default:             result_o = '0;
        endcase
    end

    // one operation in flight across the execute unit
    a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy |-> !start_i);

endmodule

`default_nettype wire

// ==== src/ex_divider.sv ====
`default_nettype none

module ex_divider (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    start_i,
    input  ex_pkg::ex_op_e          op_i,
    input  logic [ex_pkg::XLEN-1:0] op1_i,
    input  logic [ex_pkg::XLEN-1:0] op2_i,
    output logic [ex_pkg::XLEN-1:0] result_o,
    output logic                    done_o
);

    import ex_pkg::*;

    localparam int CNT_W = $clog2(ITER_COUNT);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    ex_op_e           op_q;
    logic [XLEN-1:0]  dvd_q;
    logic [XLEN-1:0]  dvs_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  quo_q;
    logic             quo_neg_q;
    logic             rem_neg_q;
    logic             zero_q;
    logic             is_word;
    logic             is_signed;
    logic             dvd_sbit;
    logic             dvs_sbit;
    logic [XLEN-1:0]  dvd_ext;
    logic [XLEN-1:0]  dvs_ext;
    logic             dvd_neg;
    logic             dvs_neg;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;
    logic [XLEN-1:0]  quo_fix;
    logic [XLEN-1:0]  rem_fix;

    assign is_word   = op_i inside {DIVW, DIVUW, REMW, REMUW};
    assign is_signed = op_i inside {DIV, REM, DIVW, REMW};

    // word forms work on the low half, extended to full width
    assign dvd_sbit = is_signed & op1_i[31];
    assign dvs_sbit = is_signed & op2_i[31];
    assign dvd_ext  = is_word ? {{(XLEN-32){dvd_sbit}}, op1_i[31:0]} : op1_i;
    assign dvs_ext  = is_word ? {{(XLEN-32){dvs_sbit}}, op2_i[31:0]} : op2_i;
    assign dvd_neg  = is_signed & dvd_ext[XLEN-1];
    assign dvs_neg  = is_signed & dvs_ext[XLEN-1];

    // restoring step keeps the old remainder on a borrow
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(ITER_COUNT - 1)) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end else if (start_i) begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (busy) begin
            rem_q <= diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN]};
        end else if (start_i) begin
            op_q      <= op_i;
            dvd_q     <= dvd_ext;
            dvs_q     <= dvs_neg ? -dvs_ext : dvs_ext;
            quo_q     <= dvd_neg ? -dvd_ext : dvd_ext;
            rem_q     <= '0;
            quo_neg_q <= dvd_neg ^ dvs_neg;
            rem_neg_q <= dvd_neg;
            zero_q    <= (dvs_ext == '0);
        end
    end

    // overflow case falls out of the magnitude math unchanged
    assign quo_fix = zero_q ? '1 : (quo_neg_q ? -quo_q : quo_q);
    assign rem_fix = zero_q ? dvd_q : (rem_neg_q ? -rem_q : rem_q);

    always_comb begin
        case (op_q)
            DIV, DIVU:   result_o = quo_fix;
            REM, REMU:   result_o = rem_fix;
            DIVW, DIVUW: result_o = {{(XLEN-32){quo_fix[31]}}, quo_fix[31:0]};
            REMW, REMUW: result_o = {{(XLEN-32){rem_fix[31]}}, rem_fix[31:0]};
            default:     result_o = '0;
        endcase
    end

    a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy |-> !start_i);

    // fixed latency from start, then a single-cycle done
    a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> ##(ITER_COUNT + 1) done_o ##1 !done_o);

endmodule

`default_nettype wire

// ==== src/ex_unit.sv ====
`default_nettype none

module ex_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [1:0]              wb_adr_i,
    input  logic [ex_pkg::XLEN-1:0] wb_dat_i,
    input  logic [ex_pkg::XLEN-1:0] mul_result_i,
    input  logic                    mul_done_i,
    input  logic [ex_pkg::XLEN-1:0] div_result_i,
    input  logic                    div_done_i,
    output logic [ex_pkg::XLEN-1:0] wb_dat_o,
    output logic                    wb_ack_o,
    output ex_pkg::ex_op_e          op_o,
    output logic [ex_pkg::XLEN-1:0] op1_o,
    output logic [ex_pkg::XLEN-1:0] op2_o,
    output logic                    mul_start_o,
    output logic                    div_start_o
);

    import ex_pkg::*;

    ex_state_e       state;
    logic [XLEN-1:0] result_q;
    logic [XLEN-1:0] result_next;
    logic            req;
    logic            held;
    logic            accept;
    logic            wr_op;
    ex_op_e          new_op;
    logic            new_is_mul;
    logic            new_is_div;
    logic [XLEN-1:0] alu_res;
    logic [31:0]     addw_w;
    logic [31:0]     subw_w;
    logic [31:0]     sllw_w;
    logic [31:0]     srlw_w;
    logic [31:0]     sraw_w;

    // masked during ack so a held request is not taken twice
    assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    // result reads and opcode writes wait out a running operation
    assign held   = (state == BUSY) &&
                    (wb_we_i ? (wb_adr_i == REG_OPCODE) : (wb_adr_i == REG_RESULT));
    assign accept = req & ~held;
    assign wr_op  = accept & wb_we_i & (wb_adr_i == REG_OPCODE);

    assign new_op     = ex_op_e'(wb_dat_i[4:0]);
    assign new_is_mul = new_op inside {MUL, MULH, MULHU, MULHSU, MULW};
    assign new_is_div = new_op inside {DIV, DIVU, REM, REMU, DIVW, DIVUW, REMW, REMUW};

    assign addw_w = op1_o[31:0] + op2_o[31:0];
    assign subw_w = op1_o[31:0] - op2_o[31:0];
    assign sllw_w = op1_o[31:0] << op2_o[4:0];
    assign srlw_w = op1_o[31:0] >> op2_o[4:0];
    assign sraw_w = $signed(op1_o[31:0]) >>> op2_o[4:0];

    // alu works on the opcode being written
    always_comb begin
        case (new_op)
            ADD:     alu_res = op1_o + op2_o;
            SUB:     alu_res = op1_o - op2_o;
            SLT:     alu_res = XLEN'($signed(op1_o) < $signed(op2_o));
            SLTU:    alu_res = XLEN'(op1_o < op2_o);
            XOR:     alu_res = op1_o ^ op2_o;
            OR:      alu_res = op1_o | op2_o;
            AND:     alu_res = op1_o & op2_o;
            SLL:     alu_res = op1_o << op2_o[5:0];
            SRL:     alu_res = op1_o >> op2_o[5:0];
            SRA:     alu_res = $signed(op1_o) >>> op2_o[5:0];
            ADDW:    alu_res = {{(XLEN-32){addw_w[31]}}, addw_w};
            SUBW:    alu_res = {{(XLEN-32){subw_w[31]}}, subw_w};
            SLLW:    alu_res = {{(XLEN-32){sllw_w[31]}}, sllw_w};
            SRLW:    alu_res = {{(XLEN-32){srlw_w[31]}}, srlw_w};
            SRAW:    alu_res = {{(XLEN-32){sraw_w[31]}}, sraw_w};
            default: alu_res = '0;
        endcase
    end

    // at most one source per edge
    always_comb begin
        result_next = result_q;
        if (mul_done_i) begin
            result_next = mul_result_i;
        end else if (div_done_i) begin
            result_next = div_result_i;
        end else if (wr_op && !new_is_mul && !new_is_div) begin
            result_next = alu_res;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state       <= IDLE;
            wb_ack_o    <= 1'b0;
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
            op_o        <= ADD;
            op1_o       <= '0;
            op2_o       <= '0;
            result_q    <= '0;
        end else begin
            wb_ack_o    <= accept;
            mul_start_o <= wr_op & new_is_mul;
            div_start_o <= wr_op & new_is_div;
            result_q    <= result_next;
            if (accept && wb_we_i && (wb_adr_i == REG_OP1)) begin
                op1_o <= wb_dat_i;
            end
            if (accept && wb_we_i && (wb_adr_i == REG_OP2)) begin
                op2_o <= wb_dat_i;
            end
            if (wr_op) begin
                op_o  <= new_op;
                state <= (new_is_mul || new_is_div) ? BUSY : DONE;
            end else if (mul_done_i || div_done_i) begin
                state <= DONE;
            end
        end
    end

    always_comb begin
        case (wb_adr_i)
            REG_OP1:    wb_dat_o = op1_o;
            REG_OP2:    wb_dat_o = op2_o;
            REG_OPCODE: wb_dat_o = XLEN'(op_o);
            default:    wb_dat_o = result_q;
        endcase
    end

    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_o |-> wb_cyc_i && wb_stb_i);

    // units only answer a start we issued
    a_done_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mul_done_i || div_done_i) |-> state == BUSY);

endmodule

`default_nettype wire

// ==== src/ex_top.sv ====
`default_nettype none

module ex_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [1:0]              wb_adr_i,
    input  logic [ex_pkg::XLEN-1:0] wb_dat_i,
    output logic [ex_pkg::XLEN-1:0] wb_dat_o,
    output logic                    wb_ack_o
);

    import ex_pkg::*;

    ex_op_e          op;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic            mul_start;
    logic            mul_done;
    logic [XLEN-1:0] mul_result;
    logic            div_start;
    logic            div_done;
    logic [XLEN-1:0] div_result;

    ex_unit u_ex_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .mul_result_i (mul_result),
        .mul_done_i   (mul_done),
        .div_result_i (div_result),
        .div_done_i   (div_done),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .op_o         (op),
        .op1_o        (op1),
        .op2_o        (op2),
        .mul_start_o  (mul_start),
        .div_start_o  (div_start)
    );

    ex_multiplier u_ex_multiplier (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (mul_start),
        .op_i     (op),
        .op1_i    (op1),
        .op2_i    (op2),
        .result_o (mul_result),
        .done_o   (mul_done)
    );

    ex_divider u_ex_divider (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (div_start),
        .op_i     (op),
        .op1_i    (op1),
        .op2_i    (op2),
        .result_o (div_result),
        .done_o   (div_done)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_ex_top.sv ====
`default_nettype none

module tb_ex_top;

    import ex_pkg::*;

    localparam int NUM_OPCODES = 28;
    localparam int RAND_ROUNDS = 4;
    localparam int RAND_OPS    = NUM_OPCODES * RAND_ROUNDS;

    logic            clk;
    logic            rst_n;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [1:0]      wb_adr;
    logic [XLEN-1:0] wb_dat_w;
    logic [XLEN-1:0] wb_dat_r;
    logic            wb_ack;

    ex_op_e          row_op[$];
    logic [63:0]     row_a[$];
    logic [63:0]     row_b[$];
    logic [63:0]     row_exp[$];

    logic [31:0]     lcg_state;
    int              cycle_count;
    int              timeout_limit;
    int              ack_count;
    int              req_count;

    ex_top u_ex_top (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timed out after %0d cycles waiting for the DUT", cycle_count);
            $display("Checks failed");
            $fatal(1, "simulation stopped");
        end
    end

    // acks seen on the bus, compared with requests at the end
    always @(posedge clk) begin
        if (rst_n && wb_ack) begin
            ack_count <= ack_count + 1;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // reference model straight from the RISC-V operation rules
    function automatic logic [63:0] expected_result(input ex_op_e op, input logic [63:0] a,
                                                    input logic [63:0] b);
        logic [127:0] p;
        logic [31:0]  a32;
        logic [31:0]  b32;
        logic [63:0]  r;
        logic         ovf;
        logic         ovf32;
        a32   = a[31:0];
        b32   = b[31:0];
        ovf   = (a == 64'h8000000000000000) && (b == '1);
        ovf32 = (a32 == 32'h80000000) && (b32 == '1);
        p     = '0;
        r     = '0;
        case (op)
            ADD:    r = a + b;
            SUB:    r = a - b;
            SLT:    r = {63'd0, $signed(a) < $signed(b)};
            SLTU:   r = {63'd0, a < b};
            XOR:    r = a ^ b;
            OR:     r = a | b;
            AND:    r = a & b;
            SLL:    r = a << b[5:0];
            SRL:    r = a >> b[5:0];
            SRA:    r = (a >> b[5:0]) | (a[63] ? ~({64{1'b1}} >> b[5:0]) : 64'd0);
            ADDW:   r = sext32(a32 + b32);
            SUBW:   r = sext32(a32 - b32);
            SLLW:   r = sext32(a32 << b[4:0]);
            SRLW:   r = sext32(a32 >> b[4:0]);
            SRAW:   r = sext32((a32 >> b[4:0]) | (a32[31] ? ~(32'hffffffff >> b[4:0]) : 32'd0));
            MUL:    r = a * b;
            MULH:   p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
            MULHU:  p = {64'd0, a} * {64'd0, b};
            MULHSU: p = {{64{a[63]}}, a} * {64'd0, b};
            MULW:   r = sext32(a32 * b32);
            DIV:    r = (b == 0) ? '1 : (ovf ? a : 64'($signed(a) / $signed(b)));
            DIVU:   r = (b == 0) ? '1 : a / b;
            REM:    r = (b == 0) ? a : (ovf ? 64'd0 : 64'($signed(a) % $signed(b)));
            REMU:   r = (b == 0) ? a : a % b;
            DIVW:   r = (b32 == 0) ? '1 :
                        (ovf32 ? sext32(a32) : sext32(32'($signed(a32) / $signed(b32))));
            DIVUW:  r = (b32 == 0) ? '1 : sext32(a32 / b32);
            REMW:   r = (b32 == 0) ? sext32(a32) :
                        (ovf32 ? 64'd0 : sext32(32'($signed(a32) % $signed(b32))));
            REMUW:  r = (b32 == 0) ? sext32(a32) : sext32(a32 % b32);
            default: r = '0;
        endcase
        if (op inside {MULH, MULHU, MULHSU}) begin
            r = p[127:64];
        end
        return r;
    endfunction

    task automatic write_reg(input logic [1:0] adr, input logic [63:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        req_count++;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [63:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        req_count++;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // result read goes out right after the opcode write
    task automatic run_op(input ex_op_e op, input logic [63:0] a, input logic [63:0] b,
                          output logic [63:0] res);
        write_reg(REG_OP1, a);
        write_reg(REG_OP2, b);
        write_reg(REG_OPCODE, 64'(op));
        read_reg(REG_RESULT, res);
    endtask

    task automatic add_row(input ex_op_e op, input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] exp);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
        row_exp.push_back(exp);
    endtask

    task automatic build_table();
        add_row(ADD,    64'hffffffffffffffff, 64'h0000000000000001, 64'h0000000000000000);
        add_row(SUB,    64'h0000000000000000, 64'h0000000000000001, 64'hffffffffffffffff);
        add_row(SLT,    64'hffffffffffffffff, 64'h0000000000000001, 64'h0000000000000001);
        add_row(SLTU,   64'hffffffffffffffff, 64'h0000000000000001, 64'h0000000000000000);
        add_row(SLT,    64'h0000000000000001, 64'hffffffffffffffff, 64'h0000000000000000);
        add_row(SLTU,   64'h0000000000000001, 64'hffffffffffffffff, 64'h0000000000000001);
        add_row(XOR,    64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'h0ff00ff00ff00ff0);
        add_row(OR,     64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hfff0fff0fff0fff0);
        add_row(AND,    64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hf000f000f000f000);
        add_row(SLL,    64'h0000000000000001, 64'h000000000000003f, 64'h8000000000000000);
        // only the low six bits of the shift amount count
        add_row(SLL,    64'h0000000000000001, 64'h0000000000000043, 64'h0000000000000008);
        add_row(SRL,    64'h8000000000000000, 64'h000000000000003f, 64'h0000000000000001);
        add_row(SRA,    64'h8000000000000000, 64'h000000000000003f, 64'hffffffffffffffff);
        add_row(SRA,    64'h8000000000000000, 64'h0000000000000004, 64'hf800000000000000);
        add_row(ADDW,   64'h000000007fffffff, 64'h0000000000000001, 64'hffffffff80000000);
        add_row(SUBW,   64'h0000000000000000, 64'h0000000000000001, 64'hffffffffffffffff);
        add_row(SLLW,   64'h0000000000000001, 64'h000000000000001f, 64'hffffffff80000000);
        add_row(SRLW,   64'hffffffff80000000, 64'h0000000000000001, 64'h0000000040000000);
        add_row(SRLW,   64'h0000000080000000, 64'h0000000000000000, 64'hffffffff80000000);
        add_row(SRAW,   64'h0000000080000000, 64'h0000000000000004, 64'hfffffffff8000000);
        add_row(MUL,    64'h0000000000000003, 64'hffffffffffffffff, 64'hfffffffffffffffd);
        add_row(MULH,   64'hffffffffffffffff, 64'hffffffffffffffff, 64'h0000000000000000);
        add_row(MULHU,  64'hffffffffffffffff, 64'hffffffffffffffff, 64'hfffffffffffffffe);
        add_row(MULHSU, 64'hffffffffffffffff, 64'hffffffffffffffff, 64'hffffffffffffffff);
        add_row(MULH,   64'h8000000000000000, 64'h0000000000000002, 64'hffffffffffffffff);
        add_row(MULHU,  64'h8000000000000000, 64'h0000000000000004, 64'h0000000000000002);
        add_row(MULHSU, 64'h0000000000000002, 64'h8000000000000000, 64'h0000000000000001);
        add_row(MULW,   64'h0000000100000003, 64'h0000000200000005, 64'h000000000000000f);
        add_row(MULW,   64'h0000000000010000, 64'h0000000000008000, 64'hffffffff80000000);
        add_row(DIV,    64'hfffffffffffffff9, 64'h0000000000000002, 64'hfffffffffffffffd);
        add_row(REM,    64'hfffffffffffffff9, 64'h0000000000000002, 64'hffffffffffffffff);
        add_row(DIVU,   64'hfffffffffffffff9, 64'h0000000000000002, 64'h7ffffffffffffffc);
        add_row(REMU,   64'hfffffffffffffff9, 64'h0000000000000002, 64'h0000000000000001);
        add_row(DIV,    64'h0000000000000005, 64'h0000000000000000, 64'hffffffffffffffff);
        add_row(REM,    64'h0000000000000005, 64'h0000000000000000, 64'h0000000000000005);
        add_row(DIVU,   64'h0000000000000005, 64'h0000000000000000, 64'hffffffffffffffff);
        add_row(REMU,   64'h0000000000000005, 64'h0000000000000000, 64'h0000000000000005);
        add_row(DIV,    64'h8000000000000000, 64'hffffffffffffffff, 64'h8000000000000000);
        add_row(REM,    64'h8000000000000000, 64'hffffffffffffffff, 64'h0000000000000000);
        add_row(DIVW,   64'h00000000fffffff9, 64'h0000000000000002, 64'hfffffffffffffffd);
        add_row(REMW,   64'h00000000fffffff9, 64'h0000000000000002, 64'hffffffffffffffff);
        add_row(DIVUW,  64'h00000000fffffff9, 64'h0000000000000002, 64'h000000007ffffffc);
        add_row(REMUW,  64'h00000000fffffff9, 64'h0000000000000002, 64'h0000000000000001);
        add_row(DIVW,   64'h0000000080000000, 64'h00000000ffffffff, 64'hffffffff80000000);
        add_row(REMW,   64'h0000000080000000, 64'h00000000ffffffff, 64'h0000000000000000);
        add_row(DIVW,   64'h0000000000001234, 64'h0000000000000000, 64'hffffffffffffffff);
        add_row(REMW,   64'h0000000080000000, 64'h0000000000000000, 64'hffffffff80000000);
        // divisor is zero in its low word
        add_row(DIVUW,  64'h0000000000000005, 64'h0000000100000000, 64'hffffffffffffffff);
        add_row(REMUW,  64'h0000000080000001, 64'h0000000000000000, 64'hffffffff80000001);
    endtask

    initial begin
        logic [63:0] got;
        logic [63:0] a;
        logic [63:0] b;
        ex_op_e      op;
        clk         = 1'b0;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 2'd0;
        wb_dat_w    = '0;
        lcg_state   = 32'h9432;
        cycle_count = 0;
        ack_count   = 0;
        req_count   = 0;
        build_table();
        timeout_limit = (row_op.size() + RAND_OPS + 2) * (ITER_COUNT + 20) + 100;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(REG_RESULT, got);
        check("wb_dat_o (result after reset)", got, 64'd0);

        a = 64'h0123456789abcdef;
        b = 64'hfffffffffffffffd;
        write_reg(REG_OP1, a);
        write_reg(REG_OP2, b);
        read_reg(REG_OP1, got);
        check("wb_dat_o (op1 readback)", got, a);
        read_reg(REG_OP2, got);
        check("wb_dat_o (op2 readback)", got, b);
        // read lands while the divider is still running
        write_reg(REG_OPCODE, 64'(DIV));
        read_reg(REG_RESULT, got);
        check("wb_dat_o (result read during divide)", got, expected_result(DIV, a, b));
        read_reg(REG_OPCODE, got);
        check("wb_dat_o (opcode readback)", got, 64'd20);

        for (int i = 0; i < row_op.size(); i++) begin
            run_op(row_op[i], row_a[i], row_b[i], got);
            check($sformatf("wb_dat_o (%s, row %0d)", row_op[i].name(), i), got, row_exp[i]);
        end

        // stride 5 walks all opcodes and mixes the groups
        for (int round = 0; round < RAND_ROUNDS; round++) begin
            for (int i = 0; i < NUM_OPCODES; i++) begin
                op = ex_op_e'(5'((i * 5 + round) % NUM_OPCODES));
                a  = {next_rand(), next_rand()};
                b  = {next_rand(), next_rand()};
                if (round == 3) begin
                    b = 64'(next_rand() % 16);
                end
                run_op(op, a, b, got);
                check($sformatf("wb_dat_o (%s, a=%h b=%h)", op.name(), a, b), got,
                      expected_result(op, a, b));
            end
        end

        repeat (3) @(posedge clk);
        check("wb_ack_o count", 64'(ack_count), 64'(req_count));
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/ex_pkg.sv
src/ex_multiplier.sv
src/ex_divider.sv
src/ex_unit.sv
src/ex_top.sv
testbench/tb_ex_top.sv

// ==== Makefile ====
TOP = tb_ex_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -o sim

run: build
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir sim.log
